// ==== files.f ====
design/sram_pkg.sv
design/axi_sram_controller.sv
design/sram_controller.sv
design/sram_subsystem_top.sv
verification/async_sram_model.sv
verification/sram_subsystem_sva.sv
verification/sram_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: sram_subsystem

sources:
  - files:
      - design/sram_pkg.sv
      - design/axi_sram_controller.sv
      - design/sram_controller.sv
      - design/sram_subsystem_top.sv
  - target: test
    files:
      - verification/async_sram_model.sv
      - verification/sram_subsystem_sva.sv
      - verification/sram_subsystem_tb.sv

// ==== verification/sram_stim.txt ====
# op addr data strb resp rdata, all hex; resp 0 is okay and 2 is slverr
# B sends write and read together; resp is the write's, rdata is what the read returns
R 00100 0000 3 0 0100
R 5a0c3 0000 3 0 f0c3
W 00010 1234 3 0 0000
R 00010 0000 3 0 1234
W 00020 beef 3 0 0000
W 00020 dead 1 2 0000
R 00020 0000 3 0 beef
W 00020 cafe 2 2 0000
R 00020 0000 3 0 beef
B 00030 1111 3 0 0030
B 00030 2222 3 0 2222
B 00030 3333 3 0 2222
B 00030 4444 3 0 4444
R 00030 0000 3 0 4444
W fffff a5a5 3 0 0000
R fffff 0000 3 0 a5a5
B 80000 0f0f 3 0 8000
B 80000 f0f0 3 0 f0f0
R 80000 0000 3 0 f0f0
W 00040 7777 3 0 0000
B 00040 8888 1 2 7777
R 00040 0000 3 0 7777

// ==== verification/sram_subsystem_tb.sv ====
`default_nettype none

module sram_subsystem_tb;

  localparam string stim_path = "verification/sram_stim.txt";

  logic                        axi_clk = 1'b0;
  logic                        axi_resetn;
  logic [sram_pkg::addr_w-1:0] awaddr;
  logic                        awvalid;
  logic [sram_pkg::data_w-1:0] wdata;
  logic [sram_pkg::strb_w-1:0] wstrb;
  logic                        wvalid;
  logic                        bready;
  logic [sram_pkg::addr_w-1:0] araddr;
  logic                        arvalid;
  logic                        rready;

  wire                         awready;
  wire                         wready;
  wire  [1:0]                  bresp;
  wire                         bvalid;
  wire                         arready;
  wire  [sram_pkg::data_w-1:0] rdata;
  wire  [1:0]                  rresp;
  wire                         rvalid;
  wire  [sram_pkg::addr_w-1:0] sram_addr;
  wire  [sram_pkg::data_w-1:0] sram_data;
  wire                         sram_we_n;
  wire                         sram_oe_n;
  wire                         sram_ce_n;

  // one entry per stimulus line
  logic [7:0]                  op_q[$];
  logic [sram_pkg::addr_w-1:0] addr_q[$];
  logic [sram_pkg::data_w-1:0] data_q[$];
  logic [sram_pkg::strb_w-1:0] strb_q[$];
  logic [1:0]                  resp_q[$];
  logic [sram_pkg::data_w-1:0] rdata_q[$];
  int                          n_lines = 0;

  always #2 axi_clk = ~axi_clk;

  sram_subsystem_top #(
    .access_cycles (2)
  ) u_dut (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n)
  );

  async_sram_model u_sram (
    .addr (sram_addr),
    .data (sram_data),
    .ce_n (sram_ce_n),
    .oe_n (sram_oe_n),
    .we_n (sram_we_n)
  );

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERROR time %0t signal %s expected %0h got %0h",
               $time, name, expected, actual);
      stop_with_failure({"wrong value on ", name});
    end
  endtask

  task automatic check_idle_outputs();
    check_value("awready", 0, awready);
    check_value("wready", 0, wready);
    check_value("arready", 0, arready);
    check_value("bvalid", 0, bvalid);
    check_value("rvalid", 0, rvalid);
    check_value("sram_ce_n", 1, sram_ce_n);
    check_value("sram_oe_n", 1, sram_oe_n);
    check_value("sram_we_n", 1, sram_we_n);
  endtask

  // called on a rising edge, returns on the edge where bready transfers
  task automatic send_write(input logic [sram_pkg::addr_w-1:0] addr,
                            input logic [sram_pkg::data_w-1:0] data,
                            input logic [sram_pkg::strb_w-1:0] strb,
                            input logic [1:0] exp_resp, output time done_at);
    int         stall;
    logic [1:0] held;
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    @(negedge axi_clk);
    while (!awready) @(negedge axi_clk);
    check_value("wready", 1, wready);
    @(posedge axi_clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge axi_clk);
    while (!bvalid) @(negedge axi_clk);
    done_at = $time;
    held = bresp;
    check_value("bresp", exp_resp, bresp);
    stall = $urandom % 5;
    // response has to sit still while bready is low
    repeat (stall) begin
      @(negedge axi_clk);
      check_value("bvalid", 1, bvalid);
      check_value("bresp", held, bresp);
    end
    @(posedge axi_clk);
    bready <= 1'b1;
    @(negedge axi_clk);
    check_value("bvalid", 1, bvalid);
    @(posedge axi_clk);
    bready <= 1'b0;
  endtask

  task automatic send_read(input logic [sram_pkg::addr_w-1:0] addr,
                           input logic [1:0] exp_resp,
                           input logic [sram_pkg::data_w-1:0] exp_rdata,
                           output time done_at);
    int                          stall;
    logic [sram_pkg::data_w-1:0] held;
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge axi_clk);
    while (!arready) @(negedge axi_clk);
    @(posedge axi_clk);
    arvalid <= 1'b0;
    @(negedge axi_clk);
    while (!rvalid) @(negedge axi_clk);
    done_at = $time;
    held = rdata;
    check_value("rresp", exp_resp, rresp);
    check_value("rdata", exp_rdata, rdata);
    stall = $urandom % 5;
    repeat (stall) begin
      @(negedge axi_clk);
      check_value("rvalid", 1, rvalid);
      check_value("rresp", exp_resp, rresp);
      check_value("rdata", held, rdata);
    end
    @(posedge axi_clk);
    rready <= 1'b1;
    @(negedge axi_clk);
    check_value("rvalid", 1, rvalid);
    @(posedge axi_clk);
    rready <= 1'b0;
  endtask

  initial begin
    int          fd;
    int          code;
    string       text;
    logic [7:0]  op_c;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_strb;
    logic [31:0] f_resp;
    logic [31:0] f_rdata;
    int          gap;
    time         t_write;
    time         t_read;
    logic        write_won;
    logic        last_write_won;
    logic        seen_b;

    void'($urandom(32'h4c75));
    seen_b     = 1'b0;
    axi_resetn = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;

    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      stop_with_failure("could not open the stimulus file");
    end
    while (!$feof(fd)) begin
      code = $fgets(text, fd);
      // skip comments and blank lines
      if (code > 0 && text.len() > 1 && text[0] != "#") begin
        code = $sscanf(text, "%c %h %h %h %h %h", op_c, f_addr, f_data, f_strb, f_resp,
                       f_rdata);
        if (code != 6) begin
          stop_with_failure({"stimulus line could not be parsed: ", text});
        end
        op_q.push_back(op_c);
        addr_q.push_back(f_addr[sram_pkg::addr_w-1:0]);
        data_q.push_back(f_data[sram_pkg::data_w-1:0]);
        strb_q.push_back(f_strb[sram_pkg::strb_w-1:0]);
        resp_q.push_back(f_resp[1:0]);
        rdata_q.push_back(f_rdata[sram_pkg::data_w-1:0]);
      end
    end
    $fclose(fd);
    if (op_q.size() == 0) begin
      stop_with_failure("the stimulus file holds no transactions");
    end
    n_lines = op_q.size();

    // outputs must be quiet in reset and just after it
    repeat (3) begin
      @(negedge axi_clk);
      check_idle_outputs();
    end
    @(posedge axi_clk);
    axi_resetn <= 1'b1;
    repeat (2) begin
      @(negedge axi_clk);
      check_idle_outputs();
    end

    foreach (op_q[i]) begin
      gap = $urandom % 4;
      repeat (gap) @(posedge axi_clk);
      @(posedge axi_clk);
      case (op_q[i])
        "W": send_write(addr_q[i], data_q[i], strb_q[i], resp_q[i], t_write);
        "R": send_read(addr_q[i], resp_q[i], rdata_q[i], t_read);
        "B": begin
          fork
            send_write(addr_q[i], data_q[i], strb_q[i], resp_q[i], t_write);
            send_read(addr_q[i], 2'b00, rdata_q[i], t_read);
          join
          // contested pairs take turns
          write_won = (t_write < t_read);
          if (seen_b) begin
            check_value("write_completed_first", !last_write_won, write_won);
          end
          seen_b         = 1'b1;
          last_write_won = write_won;
        end
        default: stop_with_failure("unknown operation in the stimulus file");
      endcase
    end

    repeat (4) @(posedge axi_clk);
    if (u_dut.u_sva.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      stop_with_failure("the bound protocol checker flagged a violation");
    end
  end

  // limit scales with the number of stimulus lines
  initial begin
    wait (n_lines > 0);
    #(n_lines * 200);
    stop_with_failure("timed out before the stimulus list finished");
  end

  initial begin
    wait (u_dut.u_sva.fail_count != 0);
    stop_with_failure("the bound protocol checker flagged a violation");
  end

endmodule

`default_nettype wire

// ==== verification/sram_subsystem_sva.sv ====
`default_nettype none

module sram_subsystem_sva (
  input  wire                         axi_clk,
  input  wire                         axi_resetn,
  input  wire                         bvalid,
  input  wire                         bready,
  input  wire [1:0]                   bresp,
  input  wire                         rvalid,
  input  wire                         rready,
  input  wire [1:0]                   rresp,
  input  wire [sram_pkg::data_w-1:0]  rdata,
  input  wire                         req,
  input  wire                         ack,
  input  wire                         sram_we_n,
  input  wire                         sram_oe_n,
  input  wire                         sram_ce_n
);

  // number of assertion failures so far
  int fail_count = 0;

  b_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $error("bvalid dropped or bresp changed before bready");
      fail_count++;
    end

  r_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $error("rvalid dropped or read payload changed before rready");
      fail_count++;
    end

  // the chip must never see a read and a write strobe at once
  oe_we_exclusive: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    sram_oe_n || sram_we_n)
    else begin
      $error("sram_oe_n and sram_we_n both low");
      fail_count++;
    end

  ack_needs_req: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    $rose(ack) |-> req)
    else begin
      $error("ack rose while req was low");
      fail_count++;
    end

  reset_idle: assert property (@(posedge axi_clk)
    !axi_resetn |=> sram_ce_n && sram_oe_n && sram_we_n && !req && !ack)
    else begin
      $error("strobes or link not idle after a reset cycle");
      fail_count++;
    end

endmodule

bind sram_subsystem_top sram_subsystem_sva u_sva (
  .axi_clk    (axi_clk),
  .axi_resetn (axi_resetn),
  .bvalid     (bvalid),
  .bready     (bready),
  .bresp      (bresp),
  .rvalid     (rvalid),
  .rready     (rready),
  .rresp      (rresp),
  .rdata      (rdata),
  .req        (req),
  .ack        (ack),
  .sram_we_n  (sram_we_n),
  .sram_oe_n  (sram_oe_n),
  .sram_ce_n  (sram_ce_n)
);

`default_nettype wire

// ==== verification/async_sram_model.sv ====
`default_nettype none

module async_sram_model (
  input  wire [sram_pkg::addr_w-1:0]  addr,
  inout  wire [sram_pkg::data_w-1:0]  data,
  input  wire                         ce_n,
  input  wire                         oe_n,
  input  wire                         we_n
);

  logic [sram_pkg::data_w-1:0] mem [logic [sram_pkg::addr_w-1:0]];
  logic [sram_pkg::data_w-1:0] rd_word;
  logic [sram_pkg::addr_w-1:0] wr_addr;
  logic [sram_pkg::data_w-1:0] wr_data;
  logic                        wr_seen = 1'b0;

  // unwritten words read back the low address bits xor'd with the top nibble
  function automatic logic [sram_pkg::data_w-1:0] read_word(
    input logic [sram_pkg::addr_w-1:0] a
  );
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a[15:0] ^ {a[19:16], 12'h000};
  endfunction

  always @(addr, ce_n, oe_n, we_n) begin
    rd_word = read_word(addr);
  end

  assign data = (!ce_n && !oe_n && we_n) ? rd_word : {sram_pkg::data_w{1'bz}};

  // keep the last valid bus value seen during the write pulse
  always @(addr, data, ce_n, we_n) begin
    if (!ce_n && !we_n && !$isunknown(data)) begin
      wr_addr = addr;
      wr_data = data;
      wr_seen = 1'b1;
    end
  end

  always @(posedge we_n) begin
    if (wr_seen) begin
      mem[wr_addr] = wr_data;
      wr_seen = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/sram_subsystem_top.sv ====
`default_nettype none

module sram_subsystem_top #(
  parameter int access_cycles = 2
) (
  input  wire                          axi_clk,
  input  wire                          axi_resetn,

  input  wire  [sram_pkg::addr_w-1:0]  awaddr,
  input  wire                          awvalid,
  output logic                         awready,

  input  wire  [sram_pkg::data_w-1:0]  wdata,
  input  wire  [sram_pkg::strb_w-1:0]  wstrb,
  input  wire                          wvalid,
  output logic                         wready,

  output sram_pkg::axi_resp_e          bresp,
  output logic                         bvalid,
  input  wire                          bready,

  input  wire  [sram_pkg::addr_w-1:0]  araddr,
  input  wire                          arvalid,
  output logic                         arready,

  output logic [sram_pkg::data_w-1:0]  rdata,
  output sram_pkg::axi_resp_e          rresp,
  output logic                         rvalid,
  input  wire                          rready,

  // async sram chip
  output logic [sram_pkg::addr_w-1:0]  sram_addr,
  inout  wire  [sram_pkg::data_w-1:0]  sram_data,
  output logic                         sram_we_n,
  output logic                         sram_oe_n,
  output logic                         sram_ce_n
);

  // link between the axi side and the pin sequencer
  logic                req;
  logic                ack;
  sram_pkg::sram_cmd_t cmd;
  sram_pkg::sram_rsp_t rsp;

  axi_sram_controller u_axi_ctrl (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .req        (req),
    .cmd        (cmd),
    .ack        (ack),
    .rsp        (rsp)
  );

  sram_controller #(
    .access_cycles (access_cycles)
  ) u_sram_ctrl (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .req        (req),
    .cmd        (cmd),
    .ack        (ack),
    .rsp        (rsp),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n)
  );

endmodule

`default_nettype wire

// ==== design/sram_controller.sv ====
`default_nettype none

module sram_controller #(
  parameter int access_cycles = 2
) (
  input  wire                          axi_clk,
  input  wire                          axi_resetn,

  // four-phase command port
  input  wire                          req,
  input  wire  sram_pkg::sram_cmd_t    cmd,
  output logic                         ack,
  output sram_pkg::sram_rsp_t          rsp,

  // chip pins
  output logic [sram_pkg::addr_w-1:0]  sram_addr,
  inout  wire  [sram_pkg::data_w-1:0]  sram_data,
  output logic                         sram_we_n,
  output logic                         sram_oe_n,
  output logic                         sram_ce_n
);

  localparam int cnt_w = (access_cycles > 1) ? $clog2(access_cycles) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(access_cycles - 1);

  if (access_cycles < 1) begin : g_bad_access_cycles
    $error("access_cycles must be at least 1");
  end

  sram_pkg::pin_state_e state;

  // remaining access cycles after the current one
  logic [cnt_w-1:0] cnt;

  logic                        wr_q;
  logic                        drive;
  logic [sram_pkg::data_w-1:0] wdata_q;

  // bus is ours only while a write is set up and strobed
  assign sram_data = drive ? wdata_q : {sram_pkg::data_w{1'bz}};

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state     <= sram_pkg::pin_idle;
      cnt       <= '0;
      ack       <= 1'b0;
      drive     <= 1'b0;
      sram_ce_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_we_n <= 1'b1;
    end else begin
      case (state)
        sram_pkg::pin_idle: begin
          if (req) begin
            // address and write data go out during setup
            drive <= cmd.write;
            state <= sram_pkg::pin_setup;
          end
        end

        sram_pkg::pin_setup: begin
          sram_ce_n <= 1'b0;
          sram_oe_n <= wr_q;
          sram_we_n <= !wr_q;
          cnt       <= cnt_last;
          state     <= sram_pkg::pin_access;
        end

        sram_pkg::pin_access: begin
          if (cnt == '0) begin
            sram_ce_n <= 1'b1;
            sram_oe_n <= 1'b1;
            sram_we_n <= 1'b1;
            drive     <= 1'b0;
            ack       <= 1'b1;
            state     <= sram_pkg::pin_done;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end

        sram_pkg::pin_done: begin
          // hold ack until the requester lets go
          if (!req) begin
            ack   <= 1'b0;
            state <= sram_pkg::pin_idle;
          end
        end

        default: begin
          ack       <= 1'b0;
          drive     <= 1'b0;
          sram_ce_n <= 1'b1;
          sram_oe_n <= 1'b1;
          sram_we_n <= 1'b1;
          state     <= sram_pkg::pin_idle;
        end
      endcase
    end
  end

  // command capture and read data
  always_ff @(posedge axi_clk) begin
    if (state == sram_pkg::pin_idle && req) begin
      wr_q      <= cmd.write;
      sram_addr <= cmd.addr;
      wdata_q   <= cmd.wdata;
    end

    // sample at the end of the last cycle with oe_n low
    if (state == sram_pkg::pin_access && cnt == '0 && !wr_q) begin
      rsp.rdata <= sram_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/axi_sram_controller.sv ====
`default_nettype none

module axi_sram_controller (
  input  wire                          axi_clk,
  input  wire                          axi_resetn,

  // write address channel
  input  wire  [sram_pkg::addr_w-1:0]  awaddr,
  input  wire                          awvalid,
  output logic                         awready,

  // write data channel
  input  wire  [sram_pkg::data_w-1:0]  wdata,
  input  wire  [sram_pkg::strb_w-1:0]  wstrb,
  input  wire                          wvalid,
  output logic                         wready,

  // write response channel
  output sram_pkg::axi_resp_e          bresp,
  output logic                         bvalid,
  input  wire                          bready,

  // read address channel
  input  wire  [sram_pkg::addr_w-1:0]  araddr,
  input  wire                          arvalid,
  output logic                         arready,

  // read data channel
  output logic [sram_pkg::data_w-1:0]  rdata,
  output sram_pkg::axi_resp_e          rresp,
  output logic                         rvalid,
  input  wire                          rready,

  // four-phase link to the pin sequencer
  output logic                         req,
  output sram_pkg::sram_cmd_t          cmd,
  input  wire                          ack,
  input  wire  sram_pkg::sram_rsp_t    rsp
);

  sram_pkg::arb_state_e state;

  // which side wins the next contested grant
  logic write_first;

  logic write_pending;
  logic read_pending;
  logic can_accept;
  logic contested;
  logic grant_write;
  logic grant_read;
  logic full_word;

  // a write needs both address and data before it can compete
  assign write_pending = awvalid && wvalid;
  assign read_pending  = arvalid;

  // previous exchange must be fully closed, ack included
  assign can_accept = (state == sram_pkg::idle) && !ack;
  assign contested  = write_pending && read_pending;

  assign grant_write = can_accept && write_pending && (!read_pending || write_first);
  assign grant_read  = can_accept && read_pending && !grant_write;

  // ready is only high in the single idle cycle where the grant is made
  assign awready = grant_write;
  assign wready  = grant_write;
  assign arready = grant_read;

  // only whole-word writes reach the chip
  assign full_word = &wstrb;

  // reads from the chip cannot fail
  assign rresp = sram_pkg::okay;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state       <= sram_pkg::idle;
      write_first <= 1'b0;
      req         <= 1'b0;
      bvalid      <= 1'b0;
      rvalid      <= 1'b0;
    end else begin
      // flip only when both sides asked, so back-to-back pairs alternate
      if (contested && can_accept) begin
        write_first <= !write_first;
      end

      case (state)
        sram_pkg::idle: begin
          if (grant_write) begin
            if (full_word) begin
              req   <= 1'b1;
              state <= sram_pkg::write_issue;
            end else begin
              // partial strobes, answer without touching the chip
              bvalid <= 1'b1;
              state  <= sram_pkg::reject_resp;
            end
          end else if (grant_read) begin
            req   <= 1'b1;
            state <= sram_pkg::read_issue;
          end
        end

        sram_pkg::write_issue: begin
          if (ack) begin
            req    <= 1'b0;
            bvalid <= 1'b1;
            state  <= sram_pkg::write_resp;
          end
        end

        sram_pkg::read_issue: begin
          if (ack) begin
            req    <= 1'b0;
            rvalid <= 1'b1;
            state  <= sram_pkg::read_resp;
          end
        end

        sram_pkg::write_resp,
        sram_pkg::reject_resp: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= sram_pkg::idle;
          end
        end

        sram_pkg::read_resp: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= sram_pkg::idle;
          end
        end

        default: begin
          req    <= 1'b0;
          bvalid <= 1'b0;
          rvalid <= 1'b0;
          state  <= sram_pkg::idle;
        end
      endcase
    end
  end

  // command and response payload
  always_ff @(posedge axi_clk) begin
    if (grant_write) begin
      cmd.write <= 1'b1;
      cmd.addr  <= awaddr;
      cmd.wdata <= wdata;
      if (full_word) begin
        bresp <= sram_pkg::okay;
      end else begin
        bresp <= sram_pkg::slverr;
      end
    end else if (grant_read) begin
      cmd.write <= 1'b0;
      cmd.addr  <= araddr;
    end

    // rsp is valid for as long as ack is high
    if (state == sram_pkg::read_issue && ack) begin
      rdata <= rsp.rdata;
    end
  end

endmodule

`default_nettype wire

// ==== design/sram_pkg.sv ====
`default_nettype none

package sram_pkg;

  // sram chip geometry, also used as the axi-lite address and data width
  localparam int addr_w = 20;
  localparam int data_w = 16;
  localparam int strb_w = data_w / 8;

  // axi response codes
  typedef enum logic [1:0] {
    okay   = 2'b00,
    slverr = 2'b10
  } axi_resp_e;

  // axi side transaction fsm
  typedef enum logic [2:0] {
    idle,
    write_issue,
    write_resp,
    read_issue,
    read_resp,
    reject_resp
  } arb_state_e;

  // chip pin sequencer
  typedef enum logic [1:0] {
    pin_idle,
    pin_setup,
    pin_access,
    pin_done
  } pin_state_e;

  // command held stable while req is high
  typedef struct packed {
    logic              write;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } sram_cmd_t;

  // result held stable while ack is high
  typedef struct packed {
    logic [data_w-1:0] rdata;
  } sram_rsp_t;

endpackage

`default_nettype wire
